// File: verilog/dmem_config.svh
// Data memory wrapper configuration
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// Address fields
`define DMEM_CORE_MSB      31
`define DMEM_CORE_LSB      24
`define DMEM_REGION_MSB    23
`define DMEM_REGION_LSB    20
`define DMEM_REGION_DATA   4'd1
`define DMEM_REGION_CR     4'd2

// Memory geometry, word address widths
`define DMEM_DATA_AW       10
`define DMEM_CR_AW         6
`define DMEM_IMEM_MSB      32'd15

// ==================================================
// CR word offsets, per-thread groups take base + thread
// ==================================================
`define DMEM_CR_THREAD_ID  0
`define DMEM_CR_CORE_ID    1
`define DMEM_CR_STK_OFST   2
`define DMEM_CR_TLS_OFST   3
`define DMEM_CR_SHRD_OFST  4
`define DMEM_CR_IMEM_MSB   5
`define DMEM_CR_DMEM_MSB   6
`define DMEM_CR_STATUS     8
`define DMEM_CR_EXCEPTION  12
`define DMEM_CR_PC         16
`define DMEM_CR_DFD_ID     20
`define DMEM_CR_SCRATCH    24
`define DMEM_CR_PC_RST     28
`define DMEM_CR_PC_EN      32
`define DMEM_CR_STK_BASE   36
`define DMEM_CR_TLS_BASE   40

// Reset offsets
`define DMEM_STK_RST_0     32'h0040_0200
`define DMEM_STK_RST_1     32'h0040_0400
`define DMEM_STK_RST_2     32'h0040_0600
`define DMEM_STK_RST_3     32'h0040_0800
`define DMEM_TLS_RST_0     32'h0040_0200
`define DMEM_TLS_RST_1     32'h0040_0400
`define DMEM_TLS_RST_2     32'h0040_0600
`define DMEM_TLS_RST_3     32'h0040_0800
`define DMEM_SHRD_OFST     32'h0040_0F00

// Response queue depth, also the core's initial credits
`define DMEM_CREDITS       4

`endif

// File: verilog/dmem_pkg.sv
// Data memory wrapper types
package dmem_pkg;

    // ==================================================
    // Core request
    // ==================================================
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  byte_en;
        logic [31:0] wr_data;
        logic        wr;
        // One-hot thread of the issuing context
        logic [3:0]  thread;
        logic [31:0] pc;
    } dmem_req_t;

    // Request after decode, hits already qualified by local core match
    typedef struct packed {
        dmem_req_t   req;
        logic [1:0]  thread_id;
        logic        data_hit;
        logic        cr_hit;
    } dmem_dec_t;

    // ==================================================
    // Response back to the core
    // ==================================================
    typedef struct packed {
        logic [31:0] rd_data;
        logic        wr;
        logic [3:0]  thread;
    } dmem_rsp_t;

    // Per-thread control bits seen by the core
    typedef struct packed {
        logic        pc_rst;
        logic        pc_en;
        logic [4:0]  dfd_id;
    } dmem_thread_cr_t;

    // Thread 0 sits at index 0
    typedef struct packed {
        dmem_thread_cr_t [3:0] thread;
    } dmem_core_cr_t;

endpackage

// File: verilog/dmem_addr_decode.sv
// Request decode stage
`include "dmem_config.svh"

module dmem_addr_decode (
    input  logic                clock,
    input  logic                reset,
    input  logic                req_valid,
    input  dmem_pkg::dmem_req_t req,
    input  logic [7:0]          core_id,
    output logic                dec_valid,
    output dmem_pkg::dmem_dec_t dec
);

    logic                core_match;
    logic [3:0]          region;
    dmem_pkg::dmem_dec_t dec_next;

    // Core field 0 always means the local core
    assign core_match = (req.addr[`DMEM_CORE_MSB:`DMEM_CORE_LSB] == 8'd0) ||
                        (req.addr[`DMEM_CORE_MSB:`DMEM_CORE_LSB] == core_id);
    assign region     = req.addr[`DMEM_REGION_MSB:`DMEM_REGION_LSB];

    always_comb begin
        dec_next.req      = req;
        dec_next.data_hit = core_match && (region == `DMEM_REGION_DATA);
        dec_next.cr_hit   = core_match && (region == `DMEM_REGION_CR);
        // One-hot to index, anything irregular falls to thread 3
        case (req.thread)
            4'b0001: dec_next.thread_id = 2'd0;
            4'b0010: dec_next.thread_id = 2'd1;
            4'b0100: dec_next.thread_id = 2'd2;
            default: dec_next.thread_id = 2'd3;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge clock) begin
        dec <= dec_next;
    end

endmodule

// File: verilog/dmem_data_sram.sv
// Byte-enabled data SRAM
`include "dmem_config.svh"

module dmem_data_sram (
    input  logic                clock,
    input  logic                dec_valid,
    input  dmem_pkg::dmem_dec_t dec,
    output logic [31:0]         sram_q
);

    logic [31:0]              mem [0:(1 << `DMEM_DATA_AW)-1];
    logic [`DMEM_DATA_AW-1:0] word_addr;
    logic                     access;

    // Byte address in, word index out
    assign word_addr = dec.req.addr[`DMEM_DATA_AW+1:2];
    assign access    = dec_valid && dec.data_hit;

    always_ff @(posedge clock) begin
        if (access && dec.req.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (dec.req.byte_en[b]) begin
                    mem[word_addr][8*b +: 8] <= dec.req.wr_data[8*b +: 8];
                end
            end
        end
        // Synchronous read
        if (access && !dec.req.wr) begin
            sram_q <= mem[word_addr];
        end
    end

endmodule

// File: verilog/dmem_ctrl_regs.sv
// Control register block
`include "dmem_config.svh"

module dmem_ctrl_regs (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    dec_valid,
    input  dmem_pkg::dmem_dec_t     dec,
    input  logic [7:0]              core_id,
    output logic [31:0]             cr_q,
    output logic                    acc_valid,
    output logic                    acc_data_hit,
    output logic                    acc_cr_hit,
    output dmem_pkg::dmem_rsp_t     acc_tag,
    output dmem_pkg::dmem_core_cr_t core_cr
);

    logic [`DMEM_CR_AW-1:0]        cr_off;
    logic [(1 << `DMEM_CR_AW)-1:0] wr_sel;
    logic [31:0]                   wr_data;
    logic [31:0]                   cr_rd_data;
    logic [3:0][31:0]              stk_ofst;
    logic [3:0][31:0]              tls_ofst;
    logic [3:0][31:0]              scratch;
    logic [3:0][31:0]              last_pc;

    assign cr_off  = dec.req.addr[`DMEM_CR_AW+1:2];
    assign wr_data = dec.req.wr_data;

    // ==================================================
    // Write decode, one select per CR word
    // ==================================================
    always_comb begin
        wr_sel = '0;
        if (dec_valid && dec.cr_hit && dec.req.wr) begin
            wr_sel[cr_off] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int t = 0; t < 4; t++) begin
                core_cr.thread[t].pc_rst <= 1'b1;
                core_cr.thread[t].pc_en  <= 1'b1;
                core_cr.thread[t].dfd_id <= 5'd0;
            end
            stk_ofst <= {`DMEM_STK_RST_3, `DMEM_STK_RST_2, `DMEM_STK_RST_1, `DMEM_STK_RST_0};
            tls_ofst <= {`DMEM_TLS_RST_3, `DMEM_TLS_RST_2, `DMEM_TLS_RST_1, `DMEM_TLS_RST_0};
            scratch  <= '0;
            last_pc  <= '0;
        end else begin
            for (int t = 0; t < 4; t++) begin
                if (wr_sel[`DMEM_CR_PC_RST + t]) core_cr.thread[t].pc_rst <= wr_data[0];
                if (wr_sel[`DMEM_CR_PC_EN + t])  core_cr.thread[t].pc_en  <= wr_data[0];
                if (wr_sel[`DMEM_CR_DFD_ID + t]) core_cr.thread[t].dfd_id <= wr_data[4:0];
                if (wr_sel[`DMEM_CR_STK_BASE + t]) stk_ofst[t] <= wr_data;
                if (wr_sel[`DMEM_CR_TLS_BASE + t]) tls_ofst[t] <= wr_data;
                if (wr_sel[`DMEM_CR_SCRATCH + t])  scratch[t]  <= wr_data;
                // Last PC follows every request of the thread
                if (dec_valid && dec.thread_id == 2'(t)) begin
                    last_pc[t] <= dec.req.pc;
                end
            end
        end
    end

    // ==================================================
    // Read mux
    // ==================================================
    always_comb begin
        case (cr_off)
            `DMEM_CR_THREAD_ID: cr_rd_data = {30'd0, dec.thread_id};
            `DMEM_CR_CORE_ID:   cr_rd_data = {24'd0, core_id};
            `DMEM_CR_STK_OFST:  cr_rd_data = stk_ofst[dec.thread_id];
            `DMEM_CR_TLS_OFST:  cr_rd_data = tls_ofst[dec.thread_id];
            `DMEM_CR_SHRD_OFST: cr_rd_data = `DMEM_SHRD_OFST;
            `DMEM_CR_IMEM_MSB:  cr_rd_data = `DMEM_IMEM_MSB;
            `DMEM_CR_DMEM_MSB:  cr_rd_data = 32'(`DMEM_DATA_AW + 1);
            default:            cr_rd_data = 32'd0;
        endcase
        for (int t = 0; t < 4; t++) begin
            // Status and exception have no sources yet
            if (cr_off == `DMEM_CR_STATUS + t)    cr_rd_data = 32'd0;
            if (cr_off == `DMEM_CR_EXCEPTION + t) cr_rd_data = 32'd0;
            if (cr_off == `DMEM_CR_PC + t)        cr_rd_data = last_pc[t];
            if (cr_off == `DMEM_CR_DFD_ID + t) begin
                cr_rd_data = {27'd0, core_cr.thread[t].dfd_id};
            end
            if (cr_off == `DMEM_CR_SCRATCH + t)  cr_rd_data = scratch[t];
            if (cr_off == `DMEM_CR_PC_RST + t)   cr_rd_data = {31'd0, core_cr.thread[t].pc_rst};
            if (cr_off == `DMEM_CR_PC_EN + t)    cr_rd_data = {31'd0, core_cr.thread[t].pc_en};
            if (cr_off == `DMEM_CR_STK_BASE + t) cr_rd_data = stk_ofst[t];
            if (cr_off == `DMEM_CR_TLS_BASE + t) cr_rd_data = tls_ofst[t];
        end
    end

    // Stage two flags
    always_ff @(posedge clock) begin
        if (reset) begin
            acc_valid    <= 1'b0;
            acc_data_hit <= 1'b0;
            acc_cr_hit   <= 1'b0;
        end else begin
            acc_valid    <= dec_valid;
            acc_data_hit <= dec.data_hit;
            acc_cr_hit   <= dec.cr_hit;
        end
    end

    always_ff @(posedge clock) begin
        cr_q            <= cr_rd_data;
        acc_tag.rd_data <= 32'd0;
        acc_tag.wr      <= dec.req.wr;
        acc_tag.thread  <= dec.req.thread;
    end

endmodule

// File: verilog/dmem_rsp_queue.sv
// Response queue with credit return
`include "dmem_config.svh"

module dmem_rsp_queue (
    input  logic                clock,
    input  logic                reset,
    input  logic                acc_valid,
    input  logic                acc_data_hit,
    input  logic                acc_cr_hit,
    input  dmem_pkg::dmem_rsp_t acc_tag,
    input  logic [31:0]         sram_q,
    input  logic [31:0]         cr_q,
    output logic                rsp_valid,
    output dmem_pkg::dmem_rsp_t rsp,
    input  logic                rsp_ready,
    output logic                credit_return
);

    localparam int depth = `DMEM_CREDITS;
    localparam int ptr_w = $clog2(depth);

    dmem_pkg::dmem_rsp_t entries [depth];
    dmem_pkg::dmem_rsp_t push_entry;
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [ptr_w:0]      count;
    logic                push;
    logic                pop;

    // Writes carry no data
    always_comb begin
        push_entry = acc_tag;
        if (acc_tag.wr)        push_entry.rd_data = 32'd0;
        else if (acc_cr_hit)   push_entry.rd_data = cr_q;
        else if (acc_data_hit) push_entry.rd_data = sram_q;
        else                   push_entry.rd_data = 32'd0;
    end

    assign push      = acc_valid;
    assign pop       = rsp_valid && rsp_ready;
    assign rsp_valid = (count != '0);
    assign rsp       = entries[rd_ptr];

    // ==================================================
    // Pointers, occupancy and credits
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= pop;
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

endmodule

// File: verilog/dmem_wrap.sv
// Data memory wrapper top
module dmem_wrap (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [7:0]              core_id,
    input  logic                    req_valid,
    input  dmem_pkg::dmem_req_t     req,
    output logic                    rsp_valid,
    output dmem_pkg::dmem_rsp_t     rsp,
    input  logic                    rsp_ready,
    output logic                    credit_return,
    output dmem_pkg::dmem_core_cr_t core_cr
);

    logic                dec_valid;
    dmem_pkg::dmem_dec_t dec;
    logic [31:0]         sram_q;
    logic [31:0]         cr_q;
    logic                acc_valid;
    logic                acc_data_hit;
    logic                acc_cr_hit;
    dmem_pkg::dmem_rsp_t acc_tag;

    // ==================================================
    // Stage one
    // ==================================================
    dmem_addr_decode dmem_addr_decode_inst (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .core_id   (core_id),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    // Stage two, memory and CR side by side
    dmem_data_sram dmem_data_sram_inst (
        .clock     (clock),
        .dec_valid (dec_valid),
        .dec       (dec),
        .sram_q    (sram_q)
    );

    dmem_ctrl_regs dmem_ctrl_regs_inst (
        .clock        (clock),
        .reset        (reset),
        .dec_valid    (dec_valid),
        .dec          (dec),
        .core_id      (core_id),
        .cr_q         (cr_q),
        .acc_valid    (acc_valid),
        .acc_data_hit (acc_data_hit),
        .acc_cr_hit   (acc_cr_hit),
        .acc_tag      (acc_tag),
        .core_cr      (core_cr)
    );

    // Stage three
    dmem_rsp_queue dmem_rsp_queue_inst (
        .clock         (clock),
        .reset         (reset),
        .acc_valid     (acc_valid),
        .acc_data_hit  (acc_data_hit),
        .acc_cr_hit    (acc_cr_hit),
        .acc_tag       (acc_tag),
        .sram_q        (sram_q),
        .cr_q          (cr_q),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .credit_return (credit_return)
    );

endmodule

// File: verif/dmem_wrap_tb.sv
// Data memory wrapper testbench
`include "dmem_config.svh"

module dmem_wrap_tb;

    localparam int core_id_value = 1;
    localparam int num_random    = 400;
    localparam int num_words     = 16;
    localparam int num_requests  = num_random + num_words + 4 * 5;
    localparam int clock_period  = 40;

    logic                    clock;
    logic                    reset;
    logic [7:0]              core_id;
    logic                    req_valid;
    dmem_pkg::dmem_req_t     req;
    logic                    rsp_valid;
    dmem_pkg::dmem_rsp_t     rsp;
    logic                    rsp_ready;
    logic                    credit_return;
    dmem_pkg::dmem_core_cr_t core_cr;

    // Reference model state
    logic [31:0]             mem_model [0:(1 << `DMEM_DATA_AW)-1];
    logic [3:0][31:0]        stk_model;
    logic [3:0][31:0]        tls_model;
    logic [3:0][31:0]        scratch_model;
    logic [3:0][31:0]        pc_model;
    dmem_pkg::dmem_core_cr_t cr_model;
    // Model view one cycle old, matches the DUT write at E1
    dmem_pkg::dmem_core_cr_t cr_lag;
    dmem_pkg::dmem_rsp_t     exp_q [$];
    int                      credits;
    int                      outstanding;
    int                      seed = 70;

    dmem_wrap dmem_wrap_inst (
        .clock         (clock),
        .reset         (reset),
        .core_id       (core_id),
        .req_valid     (req_valid),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .credit_return (credit_return),
        .core_cr       (core_cr)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #(num_requests * 20 * clock_period);
        $display("Timeout: the responses did not all arrive in time");
        $display("Errors found");
        $fatal(1);
    end

    task automatic report_failure(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1);
    endtask

    // ==================================================
    // Protocol checks
    // ==================================================
    assert property (@(posedge clock) disable iff (reset)
        credit_return == $past(rsp_valid && rsp_ready))
        else report_failure("credit_return does not match the pop one cycle earlier");

    assert property (@(posedge clock) disable iff (reset)
        $past(reset) |-> !rsp_valid && !credit_return)
        else report_failure("rsp_valid or credit_return high after reset");

    // ==================================================
    // Reference model
    // ==================================================
    function automatic int random_below(input int n);
        return int'($unsigned($random(seed)) % 32'(n));
    endfunction

    function automatic logic [1:0] thread_index(input logic [3:0] onehot);
        if (onehot == 4'b0001) return 2'd0;
        if (onehot == 4'b0010) return 2'd1;
        if (onehot == 4'b0100) return 2'd2;
        return 2'd3;
    endfunction

    // Small spread-out set of data words
    function automatic logic [9:0] test_word(input int idx);
        return 10'((idx * 67 + 5) % (1 << `DMEM_DATA_AW));
    endfunction

    function automatic logic [31:0] make_addr(input logic [7:0] core, input logic [3:0] region,
                                              input logic [9:0] word);
        return {core, region, 8'h00, word, 2'b00};
    endfunction

    function automatic logic [31:0] cr_read(input int off, input logic [1:0] tid);
        if (off == `DMEM_CR_THREAD_ID) return 32'(tid);
        if (off == `DMEM_CR_CORE_ID) return 32'(core_id_value);
        if (off == `DMEM_CR_STK_OFST) return stk_model[tid];
        if (off == `DMEM_CR_TLS_OFST) return tls_model[tid];
        if (off == `DMEM_CR_SHRD_OFST) return `DMEM_SHRD_OFST;
        if (off == `DMEM_CR_IMEM_MSB) return `DMEM_IMEM_MSB;
        // MSB of a data byte address
        if (off == `DMEM_CR_DMEM_MSB) return 32'(`DMEM_DATA_AW + 1);
        for (int t = 0; t < 4; t++) begin
            if (off == `DMEM_CR_PC + t) return pc_model[t];
            if (off == `DMEM_CR_DFD_ID + t) return 32'(cr_model.thread[t].dfd_id);
            if (off == `DMEM_CR_SCRATCH + t) return scratch_model[t];
            if (off == `DMEM_CR_PC_RST + t) return 32'(cr_model.thread[t].pc_rst);
            if (off == `DMEM_CR_PC_EN + t) return 32'(cr_model.thread[t].pc_en);
            if (off == `DMEM_CR_STK_BASE + t) return stk_model[t];
            if (off == `DMEM_CR_TLS_BASE + t) return tls_model[t];
        end
        return 32'd0;
    endfunction

    task automatic cr_write(input int off, input logic [31:0] data);
        for (int t = 0; t < 4; t++) begin
            if (off == `DMEM_CR_PC_RST + t) cr_model.thread[t].pc_rst = data[0];
            if (off == `DMEM_CR_PC_EN + t) cr_model.thread[t].pc_en = data[0];
            if (off == `DMEM_CR_DFD_ID + t) cr_model.thread[t].dfd_id = data[4:0];
            if (off == `DMEM_CR_SCRATCH + t) scratch_model[t] = data;
            if (off == `DMEM_CR_STK_BASE + t) stk_model[t] = data;
            if (off == `DMEM_CR_TLS_BASE + t) tls_model[t] = data;
        end
    endtask

    task automatic model_request(input dmem_pkg::dmem_req_t r);
        dmem_pkg::dmem_rsp_t exp;
        logic [1:0]          tid;
        logic                local_core;
        logic [3:0]          region;
        logic [9:0]          word;
        int                  off;
        tid        = thread_index(r.thread);
        local_core = (r.addr[`DMEM_CORE_MSB:`DMEM_CORE_LSB] == 8'd0) ||
                     (r.addr[`DMEM_CORE_MSB:`DMEM_CORE_LSB] == 8'(core_id_value));
        region     = r.addr[`DMEM_REGION_MSB:`DMEM_REGION_LSB];
        word       = r.addr[11:2];
        off        = int'(r.addr[7:2]);
        exp.rd_data = 32'd0;
        exp.wr      = r.wr;
        exp.thread  = r.thread;
        if (local_core && region == `DMEM_REGION_DATA) begin
            if (r.wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (r.byte_en[b]) mem_model[word][8*b +: 8] = r.wr_data[8*b +: 8];
                end
            end else begin
                exp.rd_data = mem_model[word];
            end
        end
        if (local_core && region == `DMEM_REGION_CR) begin
            if (r.wr) cr_write(off, r.wr_data);
            else exp.rd_data = cr_read(off, tid);
        end
        // Read above sees the PC of the previous request
        pc_model[tid] = r.pc;
        exp_q.push_back(exp);
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic service_cycle();
        dmem_pkg::dmem_rsp_t exp;
        req_valid = 1'b0;
        assert (core_cr == cr_lag)
            else report_failure($sformatf("core_cr %h, expected %h", core_cr, cr_lag));
        cr_lag = cr_model;
        if (credit_return) credits++;
        rsp_ready = random_below(10) < 7;
        if (rsp_valid && rsp_ready) begin
            assert (exp_q.size() > 0)
                else report_failure("response with no request outstanding");
            exp = exp_q.pop_front();
            assert (rsp == exp)
                else report_failure($sformatf("rsp %h, expected %h", rsp, exp));
            outstanding--;
        end
        assert (outstanding <= `DMEM_CREDITS)
            else report_failure($sformatf("%0d requests outstanding", outstanding));
    endtask

    task automatic idle_cycle();
        @(negedge clock);
        service_cycle();
    endtask

    task automatic send_request(input dmem_pkg::dmem_req_t r);
        logic sent;
        sent = 1'b0;
        while (!sent) begin
            @(negedge clock);
            service_cycle();
            if (credits > 0) begin
                req_valid = 1'b1;
                req       = r;
                credits--;
                outstanding++;
                model_request(r);
                sent = 1'b1;
            end
        end
    endtask

    function automatic dmem_pkg::dmem_req_t random_request();
        dmem_pkg::dmem_req_t r;
        int                  core_pick;
        int                  region_pick;
        logic [7:0]          core;
        logic [3:0]          region;
        logic [9:0]          word;
        core_pick   = random_below(10);
        region_pick = random_below(10);
        if (core_pick < 4) core = 8'd0;
        else if (core_pick < 8) core = 8'(core_id_value);
        else core = 8'(2 + random_below(200));
        // Mostly data and CR, a few unmapped regions
        if (region_pick < 5) begin
            region = `DMEM_REGION_DATA;
            word   = test_word(random_below(num_words));
        end else if (region_pick < 9) begin
            region = `DMEM_REGION_CR;
            word   = 10'(random_below(48));
        end else begin
            region = 4'(3 + random_below(13));
            word   = test_word(random_below(num_words));
        end
        r.addr        = make_addr(core, region, word);
        r.addr[19:12] = 8'(random_below(256));
        r.byte_en     = 4'(random_below(16));
        r.wr_data     = $random(seed);
        r.wr          = random_below(2) == 1;
        if (random_below(8) < 7) r.thread = 4'b0001 << random_below(4);
        else r.thread = 4'(random_below(16));
        r.pc          = $random(seed);
        return r;
    endfunction

    initial begin
        dmem_pkg::dmem_req_t r;
        int                  offs [5];
        reset       = 1'b1;
        core_id     = 8'(core_id_value);
        req_valid   = 1'b0;
        req         = '0;
        rsp_ready   = 1'b0;
        credits     = `DMEM_CREDITS;
        outstanding = 0;
        stk_model = {`DMEM_STK_RST_3, `DMEM_STK_RST_2, `DMEM_STK_RST_1, `DMEM_STK_RST_0};
        tls_model = {`DMEM_TLS_RST_3, `DMEM_TLS_RST_2, `DMEM_TLS_RST_1, `DMEM_TLS_RST_0};
        scratch_model = '0;
        pc_model      = '0;
        for (int t = 0; t < 4; t++) begin
            cr_model.thread[t].pc_rst = 1'b1;
            cr_model.thread[t].pc_en  = 1'b1;
            cr_model.thread[t].dfd_id = 5'd0;
        end
        cr_lag = cr_model;
        offs = '{`DMEM_CR_THREAD_ID, `DMEM_CR_CORE_ID, `DMEM_CR_STK_OFST,
                 `DMEM_CR_TLS_OFST, `DMEM_CR_SHRD_OFST};
        repeat (4) @(negedge clock);
        reset = 1'b0;

        // Reset values as seen from each thread
        for (int t = 0; t < 4; t++) begin
            foreach (offs[i]) begin
                r         = '0;
                r.addr    = make_addr(8'd0, `DMEM_REGION_CR, 10'(offs[i]));
                r.thread  = 4'b0001 << t;
                r.pc      = 32'h1000 + 32'(16 * t + i);
                send_request(r);
            end
        end

        // Full-word fill so every later data read is known
        for (int i = 0; i < num_words; i++) begin
            r         = '0;
            r.addr    = make_addr(8'd0, `DMEM_REGION_DATA, test_word(i));
            r.byte_en = 4'hf;
            r.wr      = 1'b1;
            r.wr_data = {~test_word(i), 6'h2a, test_word(i), 6'h15};
            r.thread  = 4'b0001;
            r.pc      = 32'h2000 + 32'(4 * i);
            send_request(r);
        end

        for (int i = 0; i < num_random; i++) begin
            if (random_below(5) == 0) idle_cycle();
            send_request(random_request());
        end

        while (exp_q.size() != 0) idle_cycle();
        repeat (4) idle_cycle();
        assert (!rsp_valid && credits == `DMEM_CREDITS)
            else report_failure($sformatf("after drain rsp_valid %b, credits %0d",
                                          rsp_valid, credits));
        $display("No errors");
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/dmem_pkg.sv
verilog/dmem_addr_decode.sv
verilog/dmem_data_sram.sv
verilog/dmem_ctrl_regs.sv
verilog/dmem_rsp_queue.sv
verilog/dmem_wrap.sv
verif/dmem_wrap_tb.sv

// File: Makefile
# Verilator simulation of the data memory wrapper

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module dmem_wrap_tb
	./obj_dir/Vdmem_wrap_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean
